// ==== harness_defines.svh ====
// --------------------------------------
// External-device harness constants
// Bus widths, address map, latencies
// --------------------------------------

`ifndef HARNESS_DEFINES_SVH
`define HARNESS_DEFINES_SVH

// Host bus widths
`define HARNESS_ADDR_W 32
`define HARNESS_DATA_W 32
`define HARNESS_BE_W 4

// Slaves behind the demux
`define HARNESS_NUM_SLAVES 3
`define HARNESS_MEM_WORDS 1024

// Address map
`define HARNESS_MEM0_BASE 32'h0000_0000
`define HARNESS_MEM1_BASE 32'h0000_1000
`define HARNESS_GPIO_BASE 32'h0000_2000
`define HARNESS_MEM_SPAN 32'h0000_1000
`define HARNESS_GPIO_SPAN 32'h0000_0010

// GPIO counter threshold out of reset
`define HARNESS_GPIO_CNT_MAX 32'd2048

// Power switch emulation
`define HARNESS_NUM_DOMAINS 3
`define HARNESS_SWITCH_ACK_STAGES 16

`endif

// ==== harness_pkg.sv ====
// --------------------------------------
// Shared bus and power domain types
// --------------------------------------

`include "harness_defines.svh"

package harness_pkg;

  // Host bus
  typedef logic [`HARNESS_ADDR_W-1:0] addr_t;
  typedef logic [`HARNESS_DATA_W-1:0] data_t;
  typedef logic [`HARNESS_BE_W-1:0] be_t;

  // Demux port select
  typedef logic [$clog2(`HARNESS_NUM_SLAVES)-1:0] slave_idx_t;

  // Word index inside one memory
  typedef logic [$clog2(`HARNESS_MEM_WORDS)-1:0] mem_addr_t;

  // Active-low, one bit per domain
  typedef logic [`HARNESS_NUM_DOMAINS-1:0] domain_vec_t;

  // Slave ports of the demux
  localparam slave_idx_t SLV_MEM0_IDX = 2'd0;
  localparam slave_idx_t SLV_MEM1_IDX = 2'd1;
  localparam slave_idx_t SLV_GPIO_IDX = 2'd2;

endpackage

// ==== periph_bus_demux.sv ====
// --------------------------------------
// Host bus demultiplexer
// Decodes the address, routes one request
// at a time and returns its response
// --------------------------------------

`include "harness_defines.svh"

module periph_bus_demux (
  input  logic                                                clk_i,
  input  logic                                                arst_n_i,
  // Host side
  input  logic                                                host_req_i,
  input  logic                                                host_we_i,
  input  harness_pkg::addr_t                                  host_addr_i,
  input  harness_pkg::data_t                                  host_wdata_i,
  input  harness_pkg::be_t                                    host_be_i,
  output logic                                                host_gnt_o,
  output logic                                                host_rvalid_o,
  output harness_pkg::data_t                                  host_rdata_o,
  // Slave side
  output logic               [`HARNESS_NUM_SLAVES-1:0]        slv_req_o,
  output logic               [`HARNESS_NUM_SLAVES-1:0]        slv_we_o,
  output harness_pkg::addr_t [`HARNESS_NUM_SLAVES-1:0]        slv_addr_o,
  output harness_pkg::data_t [`HARNESS_NUM_SLAVES-1:0]        slv_wdata_o,
  output harness_pkg::be_t   [`HARNESS_NUM_SLAVES-1:0]        slv_be_o,
  input  logic               [`HARNESS_NUM_SLAVES-1:0]        slv_gnt_i,
  input  logic               [`HARNESS_NUM_SLAVES-1:0]        slv_rvalid_i,
  input  harness_pkg::data_t [`HARNESS_NUM_SLAVES-1:0]        slv_rdata_i
);

  import harness_pkg::*;

  slave_idx_t idx_d;
  slave_idx_t idx_q;
  logic       unmapped_d;
  logic       unmapped_q;
  logic       pending_q;
  logic       accept;
  logic       slv_resp;

  function automatic logic in_region(addr_t addr, addr_t base, addr_t span);
    addr_t offs;
    offs = addr - base;
    return offs < span;
  endfunction

  // --------------------------------------
  // Address decode
  // --------------------------------------
  always_comb begin
    idx_d      = SLV_MEM0_IDX;
    unmapped_d = 1'b0;
    if (in_region(host_addr_i, `HARNESS_MEM0_BASE, `HARNESS_MEM_SPAN)) begin
      idx_d = SLV_MEM0_IDX;
    end else if (in_region(host_addr_i, `HARNESS_MEM1_BASE, `HARNESS_MEM_SPAN)) begin
      idx_d = SLV_MEM1_IDX;
    end else if (in_region(host_addr_i, `HARNESS_GPIO_BASE, `HARNESS_GPIO_SPAN)) begin
      idx_d = SLV_GPIO_IDX;
    end else begin
      unmapped_d = 1'b1;
    end
  end

  // Request only reaches the selected slave, and only when idle
  always_comb begin
    slv_req_o = '0;
    if (host_req_i && !pending_q && !unmapped_d) begin
      slv_req_o[idx_d] = 1'b1;
    end
    for (int s = 0; s < `HARNESS_NUM_SLAVES; s++) begin
      slv_we_o[s]    = host_we_i;
      slv_addr_o[s]  = host_addr_i;
      slv_wdata_o[s] = host_wdata_i;
      slv_be_o[s]    = host_be_i;
    end
  end

  // Unmapped accesses are granted right away
  assign host_gnt_o = host_req_i && !pending_q && (unmapped_d || slv_gnt_i[idx_d]);
  assign accept     = host_req_i && host_gnt_o;

  // --------------------------------------
  // Response routing
  // --------------------------------------
  assign slv_resp      = pending_q && !unmapped_q && slv_rvalid_i[idx_q];
  assign host_rvalid_o = (pending_q && unmapped_q) || slv_resp;
  assign host_rdata_o  = slv_resp ? slv_rdata_i[idx_q] : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q  <= 1'b0;
      idx_q      <= SLV_MEM0_IDX;
      unmapped_q <= 1'b0;
    end else if (accept) begin
      pending_q  <= 1'b1;
      idx_q      <= idx_d;
      unmapped_q <= unmapped_d;
    end else if (host_rvalid_o) begin
      pending_q  <= 1'b0;
      unmapped_q <= 1'b0;
    end
  end

endmodule

// ==== slow_memory.sv ====
// --------------------------------------
// Word memory with byte enables and
// pseudo-random grant wait states
// --------------------------------------

`include "harness_defines.svh"

module slow_memory #(
  parameter int unsigned NUM_WORDS = `HARNESS_MEM_WORDS
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   req_i,
  input  logic                   we_i,
  input  harness_pkg::mem_addr_t addr_i,
  input  harness_pkg::data_t     wdata_i,
  input  harness_pkg::be_t       be_i,
  output logic                   gnt_o,
  output logic                   rvalid_o,
  output harness_pkg::data_t     rdata_o
);

  import harness_pkg::*;

  data_t      mem_q [NUM_WORDS];
  data_t      rdata_q;
  logic [7:0] lfsr_q;
  logic [1:0] delay_q;
  logic       delay_vld_q;
  logic [1:0] wait_now;
  logic       rvalid_q;

  // Free-running LFSR, x^8 + x^6 + x^5 + x^4 + 1
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lfsr_q <= 8'hA5;
    end else begin
      lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
    end
  end

  // --------------------------------------
  // Grant wait states
  // --------------------------------------
  // First cycle of a request draws 0..3 from the LFSR
  assign wait_now = delay_vld_q ? delay_q : lfsr_q[1:0];
  assign gnt_o    = req_i && (wait_now == 2'd0);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      delay_q     <= 2'd0;
      delay_vld_q <= 1'b0;
      rvalid_q    <= 1'b0;
    end else begin
      rvalid_q <= gnt_o;
      if (gnt_o) begin
        delay_vld_q <= 1'b0;
      end else if (req_i) begin
        delay_vld_q <= 1'b1;
        delay_q     <= wait_now - 2'd1;
      end
    end
  end

  // --------------------------------------
  // Storage, accessed at grant
  // --------------------------------------
  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      if (we_i) begin
        for (int b = 0; b < `HARNESS_BE_W; b++) begin
          if (be_i[b]) begin
            mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[addr_i];
      end
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule

// ==== gpio_counter.sv ====
// --------------------------------------
// GPIO rising edge counter with a
// threshold register and interrupt pulse
// --------------------------------------

`include "harness_defines.svh"

module gpio_counter (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               gpio_i,
  input  logic               req_i,
  input  logic               we_i,
  input  harness_pkg::addr_t addr_i,
  input  harness_pkg::data_t wdata_i,
  output logic               gnt_o,
  output logic               rvalid_o,
  output harness_pkg::data_t rdata_o,
  output logic               intr_o
);

  import harness_pkg::*;

  data_t thr_q;
  data_t cnt_q;
  data_t cnt_nxt;
  data_t rdata_q;
  logic  gpio_q;
  logic  rise;
  logic  hit;
  logic  rvalid_q;
  logic  intr_q;

  assign rise    = gpio_i && !gpio_q;
  assign cnt_nxt = cnt_q + 32'd1;
  assign hit     = rise && (cnt_nxt >= thr_q);

  // Registers answer in one cycle
  assign gnt_o = req_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gpio_q   <= 1'b0;
      cnt_q    <= '0;
      thr_q    <= `HARNESS_GPIO_CNT_MAX;
      intr_q   <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      gpio_q   <= gpio_i;
      intr_q   <= hit;
      rvalid_q <= req_i;
      if (hit) begin
        cnt_q <= '0;
      end else if (rise) begin
        cnt_q <= cnt_nxt;
      end
      // Only the threshold is writable
      if (req_i && we_i && addr_i[3:0] == 4'h0) begin
        thr_q <= wdata_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      case (addr_i[3:0])
        4'h0:    rdata_q <= thr_q;
        4'h4:    rdata_q <= cnt_q;
        default: rdata_q <= '0;
      endcase
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;
  assign intr_o   = intr_q;

endmodule

// ==== power_switch_emulator.sv ====
// --------------------------------------
// Power switch model, acknowledges each
// switch command after a fixed delay
// --------------------------------------

`include "harness_defines.svh"

module power_switch_emulator #(
  parameter int unsigned ACK_STAGES = `HARNESS_SWITCH_ACK_STAGES
) (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  harness_pkg::domain_vec_t cpu_switch_n_i,
  input  harness_pkg::domain_vec_t periph_switch_n_i,
  input  harness_pkg::domain_vec_t ext_switch_n_i,
  output harness_pkg::domain_vec_t cpu_switch_ack_n_o,
  output harness_pkg::domain_vec_t periph_switch_ack_n_o,
  output harness_pkg::domain_vec_t ext_switch_ack_n_o
);

  import harness_pkg::*;

  // Groups: 0 cpu, 1 peripheral, 2 external
  domain_vec_t switch_n [3];
  domain_vec_t shift_q  [3][ACK_STAGES];

  assign switch_n[0] = cpu_switch_n_i;
  assign switch_n[1] = periph_switch_n_i;
  assign switch_n[2] = ext_switch_n_i;

  // All domains read as off until the pipe fills
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int g = 0; g < 3; g++) begin
        for (int s = 0; s < ACK_STAGES; s++) begin
          shift_q[g][s] <= '1;
        end
      end
    end else begin
      for (int g = 0; g < 3; g++) begin
        shift_q[g][0] <= switch_n[g];
        for (int s = 1; s < ACK_STAGES; s++) begin
          shift_q[g][s] <= shift_q[g][s-1];
        end
      end
    end
  end

  assign cpu_switch_ack_n_o    = shift_q[0][ACK_STAGES-1];
  assign periph_switch_ack_n_o = shift_q[1][ACK_STAGES-1];
  assign ext_switch_ack_n_o    = shift_q[2][ACK_STAGES-1];

endmodule

// ==== ext_periph_harness.sv ====
// --------------------------------------
// External-device harness top level
// Bus demux, two memories, GPIO counter
// and power switch emulation
// --------------------------------------

`include "harness_defines.svh"

module ext_periph_harness (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  // Host bus
  input  logic                     host_req_i,
  input  logic                     host_we_i,
  input  harness_pkg::addr_t       host_addr_i,
  input  harness_pkg::data_t       host_wdata_i,
  input  harness_pkg::be_t         host_be_i,
  output logic                     host_gnt_o,
  output logic                     host_rvalid_o,
  output harness_pkg::data_t       host_rdata_o,
  // GPIO counter
  input  logic                     gpio_i,
  output logic                     gpio_intr_o,
  // Power switches
  input  harness_pkg::domain_vec_t cpu_switch_n_i,
  input  harness_pkg::domain_vec_t periph_switch_n_i,
  input  harness_pkg::domain_vec_t ext_switch_n_i,
  output harness_pkg::domain_vec_t cpu_switch_ack_n_o,
  output harness_pkg::domain_vec_t periph_switch_ack_n_o,
  output harness_pkg::domain_vec_t ext_switch_ack_n_o
);

  import harness_pkg::*;

  logic  [`HARNESS_NUM_SLAVES-1:0] slv_req;
  logic  [`HARNESS_NUM_SLAVES-1:0] slv_we;
  addr_t [`HARNESS_NUM_SLAVES-1:0] slv_addr;
  data_t [`HARNESS_NUM_SLAVES-1:0] slv_wdata;
  be_t   [`HARNESS_NUM_SLAVES-1:0] slv_be;
  logic  [`HARNESS_NUM_SLAVES-1:0] slv_gnt;
  logic  [`HARNESS_NUM_SLAVES-1:0] slv_rvalid;
  data_t [`HARNESS_NUM_SLAVES-1:0] slv_rdata;

  periph_bus_demux u_demux (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .host_req_i   (host_req_i),
    .host_we_i    (host_we_i),
    .host_addr_i  (host_addr_i),
    .host_wdata_i (host_wdata_i),
    .host_be_i    (host_be_i),
    .host_gnt_o   (host_gnt_o),
    .host_rvalid_o(host_rvalid_o),
    .host_rdata_o (host_rdata_o),
    .slv_req_o    (slv_req),
    .slv_we_o     (slv_we),
    .slv_addr_o   (slv_addr),
    .slv_wdata_o  (slv_wdata),
    .slv_be_o     (slv_be),
    .slv_gnt_i    (slv_gnt),
    .slv_rvalid_i (slv_rvalid),
    .slv_rdata_i  (slv_rdata)
  );

  // Memories take the word index from the byte address
  slow_memory u_mem0 (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .req_i   (slv_req[SLV_MEM0_IDX]),
    .we_i    (slv_we[SLV_MEM0_IDX]),
    .addr_i  (slv_addr[SLV_MEM0_IDX][$bits(mem_addr_t)+1:2]),
    .wdata_i (slv_wdata[SLV_MEM0_IDX]),
    .be_i    (slv_be[SLV_MEM0_IDX]),
    .gnt_o   (slv_gnt[SLV_MEM0_IDX]),
    .rvalid_o(slv_rvalid[SLV_MEM0_IDX]),
    .rdata_o (slv_rdata[SLV_MEM0_IDX])
  );

  slow_memory u_mem1 (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .req_i   (slv_req[SLV_MEM1_IDX]),
    .we_i    (slv_we[SLV_MEM1_IDX]),
    .addr_i  (slv_addr[SLV_MEM1_IDX][$bits(mem_addr_t)+1:2]),
    .wdata_i (slv_wdata[SLV_MEM1_IDX]),
    .be_i    (slv_be[SLV_MEM1_IDX]),
    .gnt_o   (slv_gnt[SLV_MEM1_IDX]),
    .rvalid_o(slv_rvalid[SLV_MEM1_IDX]),
    .rdata_o (slv_rdata[SLV_MEM1_IDX])
  );

  gpio_counter u_gpio_cnt (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .gpio_i  (gpio_i),
    .req_i   (slv_req[SLV_GPIO_IDX]),
    .we_i    (slv_we[SLV_GPIO_IDX]),
    .addr_i  (slv_addr[SLV_GPIO_IDX]),
    .wdata_i (slv_wdata[SLV_GPIO_IDX]),
    .gnt_o   (slv_gnt[SLV_GPIO_IDX]),
    .rvalid_o(slv_rvalid[SLV_GPIO_IDX]),
    .rdata_o (slv_rdata[SLV_GPIO_IDX]),
    .intr_o  (gpio_intr_o)
  );

  power_switch_emulator u_pwr_sw (
    .clk_i                (clk_i),
    .arst_n_i             (arst_n_i),
    .cpu_switch_n_i       (cpu_switch_n_i),
    .periph_switch_n_i    (periph_switch_n_i),
    .ext_switch_n_i       (ext_switch_n_i),
    .cpu_switch_ack_n_o   (cpu_switch_ack_n_o),
    .periph_switch_ack_n_o(periph_switch_ack_n_o),
    .ext_switch_ack_n_o   (ext_switch_ack_n_o)
  );

endmodule

// ==== tb_clk_gen.sv ====
// --------------------------------------
// Testbench clock and reset generator
// --------------------------------------

module tb_clk_gen #(
  parameter int PERIOD       = 10,
  parameter int RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic arst_n_o
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

// ==== tb_ext_periph_harness.sv ====
// --------------------------------------
// Testbench for the external-device harness
// Directed bus, GPIO and power switch tests
// --------------------------------------

`include "harness_defines.svh"

module tb_ext_periph_harness;

  timeunit 1ns;
  timeprecision 1ps;

  import harness_pkg::*;

  localparam int unsigned SEED       = 32'h7e28bc78;
  localparam int          CLK_PERIOD = 10;
  // Bus transfers and GPIO edges over all tests, rounded up
  localparam int          TEST_STEPS = 140;
  localparam int          HS_LIMIT   = 20;

  logic                                      clk;
  logic                                      arst_n;
  logic                                      req;
  logic                                      we;
  addr_t                                     addr;
  data_t                                     wdata;
  be_t                                       be;
  logic                                      gnt;
  logic                                      rvalid;
  data_t                                     rdata;
  logic                                      gpio;
  logic                                      gpio_intr;
  domain_vec_t [2:0]                         sw_n;
  wire [2:0][`HARNESS_NUM_DOMAINS-1:0]       ack_n;
  data_t                                     mem_ref [2][`HARNESS_MEM_WORDS];
  int                                        intr_count;

  tb_clk_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(5)) u_clk_gen (
    .clk_o   (clk),
    .arst_n_o(arst_n)
  );

  ext_periph_harness UUT (
    .clk_i                (clk),
    .arst_n_i             (arst_n),
    .host_req_i           (req),
    .host_we_i            (we),
    .host_addr_i          (addr),
    .host_wdata_i         (wdata),
    .host_be_i            (be),
    .host_gnt_o           (gnt),
    .host_rvalid_o        (rvalid),
    .host_rdata_o         (rdata),
    .gpio_i               (gpio),
    .gpio_intr_o          (gpio_intr),
    .cpu_switch_n_i       (sw_n[0]),
    .periph_switch_n_i    (sw_n[1]),
    .ext_switch_n_i       (sw_n[2]),
    .cpu_switch_ack_n_o   (ack_n[0]),
    .periph_switch_ack_n_o(ack_n[1]),
    .ext_switch_ack_n_o   (ack_n[2])
  );

  // --------------------------------------
  // Error reporting and compare tasks
  // --------------------------------------
  task automatic abort_run();
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(string msg);
    $display("Fail at %0t ns: %s", $time, msg);
    abort_run();
  endtask

  task automatic check_data(data_t got, data_t exp, string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s, got %h expected %h", what, got, exp));
    end
  endtask

  task automatic check_domain(domain_vec_t got, domain_vec_t exp, string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s, got %b expected %b", what, got, exp));
    end
  endtask

  task automatic check_intr(logic got, logic exp, string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s, got %b expected %b", what, got, exp));
    end
  endtask

  // --------------------------------------
  // Host bus driver
  // --------------------------------------
  task automatic host_transfer(input logic wr, input addr_t a, input data_t wd, input be_t b,
                               output data_t rd, output int waits);
    int n;
    @(negedge clk);
    req   = 1'b1;
    we    = wr;
    addr  = a;
    wdata = wd;
    be    = b;
    waits = 0;
    @(posedge clk);
    while (gnt !== 1'b1) begin
      waits++;
      if (waits > HS_LIMIT) begin
        $display("No grant for address %h within %0d cycles", a, HS_LIMIT);
        abort_run();
      end
      @(posedge clk);
    end
    @(negedge clk);
    req = 1'b0;
    n   = 0;
    @(posedge clk);
    while (rvalid !== 1'b1) begin
      n++;
      if (n > HS_LIMIT) begin
        $display("No read-valid for address %h within %0d cycles", a, HS_LIMIT);
        abort_run();
      end
      @(posedge clk);
    end
    rd = rdata;
  endtask

  task automatic bus_write(addr_t a, data_t d, be_t b);
    data_t rd;
    int    waits;
    host_transfer(1'b1, a, d, b, rd, waits);
  endtask

  task automatic bus_read(input addr_t a, output data_t rd);
    int waits;
    host_transfer(1'b0, a, '0, 4'hF, rd, waits);
  endtask

  function automatic addr_t word_addr(int m, int w);
    addr_t base;
    base = (m == 0) ? `HARNESS_MEM0_BASE : `HARNESS_MEM1_BASE;
    return base + addr_t'(w) * 4;
  endfunction

  // Only enabled bytes take the new data
  function automatic data_t merge_bytes(data_t old_w, data_t new_w, be_t b);
    data_t res;
    res = old_w;
    for (int i = 0; i < `HARNESS_BE_W; i++) begin
      if (b[i]) begin
        res[i*8 +: 8] = new_w[i*8 +: 8];
      end
    end
    return res;
  endfunction

  task automatic gpio_edge();
    @(negedge clk);
    gpio = 1'b1;
    repeat (2) @(negedge clk);
    gpio = 1'b0;
    repeat (2) @(negedge clk);
  endtask

  // Interrupt pulses, one count per high cycle
  always @(posedge clk) begin
    if (gpio_intr === 1'b1) begin
      intr_count++;
    end
  end

  // --------------------------------------
  // Directed tests
  // --------------------------------------
  task automatic test_switch_reset();
    // Switches already differ from the reset value, pipe not yet filled
    for (int g = 0; g < 3; g++) begin
      check_domain(ack_n[g], '1, $sformatf("group %0d acknowledge after reset", g));
    end
  endtask

  task automatic test_mem_round_trip();
    int    w [16];
    data_t d;
    data_t rd;
    for (int i = 0; i < 16; i++) begin
      w[i] = $urandom % `HARNESS_MEM_WORDS;
      for (int m = 0; m < 2; m++) begin
        d = $urandom;
        // Same index in both memories, different data
        if (m == 1 && d == mem_ref[0][w[i]]) begin
          d = ~d;
        end
        bus_write(word_addr(m, w[i]), d, 4'hF);
        mem_ref[m][w[i]] = d;
      end
    end
    for (int i = 0; i < 16; i++) begin
      for (int m = 0; m < 2; m++) begin
        bus_read(word_addr(m, w[i]), rd);
        check_data(rd, mem_ref[m][w[i]], $sformatf("mem%0d word %0d read back", m, w[i]));
      end
    end
  endtask

  task automatic test_byte_enables();
    be_t   b;
    data_t d;
    data_t rd;
    for (int m = 0; m < 2; m++) begin
      bus_write(word_addr(m, 37), 32'h1122_3344, 4'hF);
      mem_ref[m][37] = 32'h1122_3344;
      for (int i = 0; i < 4; i++) begin
        for (int j = i; j < 4; j++) begin
          b = be_t'((1 << i) | (1 << j));
          d = $urandom;
          bus_write(word_addr(m, 37), d, b);
          mem_ref[m][37] = merge_bytes(mem_ref[m][37], d, b);
          bus_read(word_addr(m, 37), rd);
          check_data(rd, mem_ref[m][37], $sformatf("mem%0d byte enables %b", m, b));
        end
      end
    end
  endtask

  task automatic test_decode();
    addr_t bad [4];
    data_t rd;
    int    waits;
    bad[0] = 32'h0000_2010;
    bad[1] = 32'h0000_3004;
    bad[2] = 32'h8000_0004;
    bad[3] = 32'hFFFF_FFFC;
    for (int m = 0; m < 2; m++) begin
      bus_write(word_addr(m, 1), 32'hA5A5_0001 + m, 4'hF);
      mem_ref[m][1] = 32'hA5A5_0001 + m;
    end
    for (int i = 0; i < 4; i++) begin
      for (int k = 0; k < 2; k++) begin
        host_transfer(k == 0, bad[i], 32'hDEAD_BEEF, 4'hF, rd, waits);
        if (waits != 0) begin
          $display("Unmapped address %h was not granted in its request cycle", bad[i]);
          abort_run();
        end
        check_data(rd, '0, $sformatf("unmapped response at %h", bad[i]));
      end
    end
    for (int m = 0; m < 2; m++) begin
      bus_read(word_addr(m, 1), rd);
      check_data(rd, mem_ref[m][1], $sformatf("mem%0d after unmapped writes", m));
    end
  endtask

  task automatic test_gpio_counter();
    data_t rd;
    bus_read(`HARNESS_GPIO_BASE, rd);
    check_data(rd, 32'd2048, "threshold after reset");
    bus_write(`HARNESS_GPIO_BASE, 32'd5, 4'hF);
    intr_count = 0;
    repeat (4) gpio_edge();
    bus_read(`HARNESS_GPIO_BASE + 4, rd);
    check_data(rd, 32'd4, "count after four edges");
    check_intr(intr_count != 0, 1'b0, "interrupt below threshold");
    // Fifth edge reaches the threshold
    @(negedge clk);
    gpio = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_intr(intr_count != 0, 1'b1, "interrupt within 3 cycles of fifth edge");
    gpio = 1'b0;
    repeat (10) @(negedge clk);
    check_intr(intr_count == 1, 1'b1, "single interrupt pulse");
    bus_read(`HARNESS_GPIO_BASE + 4, rd);
    check_data(rd, 32'd0, "count after interrupt");
    gpio_edge();
    bus_write(`HARNESS_GPIO_BASE + 4, 32'h0000_00FF, 4'hF);
    bus_read(`HARNESS_GPIO_BASE + 4, rd);
    check_data(rd, 32'd1, "count after write to count offset");
  endtask

  task automatic test_power_switch();
    domain_vec_t old_v;
    domain_vec_t new_v;
    for (int g = 0; g < 3; g++) begin
      old_v = sw_n[g];
      new_v = domain_vec_t'($urandom);
      if (new_v == old_v) begin
        new_v = ~old_v;
      end
      @(negedge clk);
      sw_n[g] = new_v;
      repeat (15) @(posedge clk);
      @(negedge clk);
      check_domain(ack_n[g], old_v, $sformatf("group %0d acknowledge at cycle 15", g));
      @(negedge clk);
      check_domain(ack_n[g], new_v, $sformatf("group %0d acknowledge at cycle 16", g));
      for (int k = 0; k < 3; k++) begin
        check_domain(ack_n[k], sw_n[k], $sformatf("group %0d held acknowledge", k));
      end
    end
  endtask

  // --------------------------------------
  // Main sequence and watchdog
  // --------------------------------------
  initial begin : main_seq
    int unsigned seed;
    int unsigned first;
    req        = 1'b0;
    we         = 1'b0;
    addr       = '0;
    wdata      = '0;
    be         = '0;
    gpio       = 1'b0;
    sw_n       = '0;
    intr_count = 0;
    seed       = SEED;
    first      = $urandom(seed);
    wait (arst_n === 1'b1);
    @(negedge clk);
    test_switch_reset();
    test_mem_round_trip();
    test_byte_enables();
    test_decode();
    test_gpio_counter();
    test_power_switch();
    $display("all tests passed");
    $finish;
  end

  initial begin : watchdog
    #(TEST_STEPS * 200 * CLK_PERIOD);
    $display("Timeout, the tests did not finish in the expected time");
    abort_run();
  end

endmodule

// ==== list.f ====
+incdir+.
harness_pkg.sv
periph_bus_demux.sv
slow_memory.sv
gpio_counter.sv
power_switch_emulator.sv
ext_periph_harness.sv
tb_clk_gen.sv
tb_ext_periph_harness.sv

// ==== Bender.yml ====
package:
  name: ext_periph_harness

export_include_dirs:
  - .

sources:
  - files:
      - harness_pkg.sv
      - periph_bus_demux.sv
      - slow_memory.sv
      - gpio_counter.sv
      - power_switch_emulator.sv
      - ext_periph_harness.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_ext_periph_harness.sv
